// ==== bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // --------------------------------------------------
    // Master-side bus sizes
    // --------------------------------------------------

    localparam int ADDR_W         = 8;
    localparam int DATA_W         = 32;
    // Four byte lanes per data word
    localparam int BYTES_PER_WORD = DATA_W / 8;
    // Bursts of 1 to 4 words
    localparam int BURSTCOUNT_W   = 3;
    localparam int MASTER_ID_W    = 1;
    localparam int NUM_MASTERS    = 2;

    // Whole byte address space is backed by the slave memory
    localparam int MEM_WORDS      = (1 << ADDR_W) / BYTES_PER_WORD;
    localparam int WORD_IDX_W     = $clog2(MEM_WORDS);

    // --------------------------------------------------
    // Bus field types
    // --------------------------------------------------

    typedef logic [ADDR_W-1:0]         addr_t;
    typedef logic [DATA_W-1:0]         data_t;
    typedef logic [BYTES_PER_WORD-1:0] byteen_t;
    typedef logic [BURSTCOUNT_W-1:0]   burstcount_t;
    typedef logic [MASTER_ID_W-1:0]    master_id_t;
    // Word index into the slave memory
    typedef logic [WORD_IDX_W-1:0]     word_idx_t;

endpackage

`default_nettype wire

// ==== pkt_pkg.sv ====
`default_nettype none

package pkt_pkg;

    // --------------------------------------------------
    // Packet field positions, low bit first
    // --------------------------------------------------

    // Routing ids
    localparam int PKT_DEST_ID_L       = 0;
    localparam int PKT_DEST_ID_H       = 0;
    localparam int PKT_SRC_ID_L        = 1;
    localparam int PKT_SRC_ID_H        = 1;

    // Byte enables, one per data byte
    localparam int PKT_BYTEEN_L        = 2;
    localparam int PKT_BYTEEN_H        = 5;

    // Write data on commands, read data on responses
    localparam int PKT_DATA_L          = 6;
    localparam int PKT_DATA_H          = 37;

    // Transaction flags
    localparam int PKT_READ            = 38;
    localparam int PKT_WRITE           = 39;
    localparam int PKT_POSTED          = 40;
    // Whole read burst carried by one beat
    localparam int PKT_COMPRESSED_READ = 41;

    // Burst length in words
    localparam int PKT_BURSTCOUNT_L    = 42;
    localparam int PKT_BURSTCOUNT_H    = 44;

    // Word aligned byte address
    localparam int PKT_ADDR_L          = 45;
    localparam int PKT_ADDR_H          = 52;

    // --------------------------------------------------
    // Packet beat
    // --------------------------------------------------

    // Address field is the topmost one
    localparam int PKT_W = PKT_ADDR_H + 1;

    typedef logic [PKT_W-1:0] pkt_t;

endpackage

`default_nettype wire

// ==== master_agent.sv ====
`timescale 1ns/10ps
`default_nettype none

module master_agent import bus_pkg::*, pkt_pkg::*; #(
    parameter master_id_t ID = master_id_t'(0)
) (
    input  wire logic        clk,
    input  wire logic        reset,

    // Master-side bus
    input  wire addr_t       address,
    input  wire logic        write,
    input  wire logic        read,
    input  wire data_t       writedata,
    input  wire byteen_t     byteenable,
    input  wire burstcount_t burstcount,
    output logic             waitrequest,
    output data_t            readdata,
    output logic             readdatavalid,

    // Command stream out
    output logic             cp_valid,
    output pkt_t             cp_data,
    output logic             cp_sop,
    output logic             cp_eop,
    input  wire logic        cp_ready,

    // Response in, always accepted
    input  wire logic        rsp_valid,
    input  wire pkt_t        rsp_data
);

    addr_t       addr_aligned;
    burstcount_t beat_cnt_q;
    logic        cmd_xfer;

    // --------------------------------------------------
    // Command packet
    // --------------------------------------------------

    // Drop the byte offset within the word
    assign addr_aligned = address & ~addr_t'(BYTES_PER_WORD - 1);

    always_comb begin
        cp_data = '0;
        // Only one slave on the fabric
        cp_data[PKT_DEST_ID_H:PKT_DEST_ID_L]       = '0;
        cp_data[PKT_SRC_ID_H:PKT_SRC_ID_L]         = ID;
        cp_data[PKT_BYTEEN_H:PKT_BYTEEN_L]         = byteenable;
        cp_data[PKT_DATA_H:PKT_DATA_L]             = writedata;
        cp_data[PKT_READ]                          = read;
        cp_data[PKT_WRITE]                         = write;
        // Writes never get a response
        cp_data[PKT_POSTED]                        = write;
        cp_data[PKT_COMPRESSED_READ]               = read & (burstcount > burstcount_t'(1));
        cp_data[PKT_BURSTCOUNT_H:PKT_BURSTCOUNT_L] = burstcount;
        cp_data[PKT_ADDR_H:PKT_ADDR_L]             = addr_aligned;
    end

    // --------------------------------------------------
    // Packet framing
    // --------------------------------------------------

    assign cp_valid = read | write;
    assign cmd_xfer = cp_valid & cp_ready;

    // First beat of a packet when no beat has gone yet
    assign cp_sop = (beat_cnt_q == '0);
    // Read burst is one beat, write burst ends on its last data word
    assign cp_eop = read | (burstcount_t'(beat_cnt_q + 1'b1) == burstcount);

    // Write beats sent so far in the current packet
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            beat_cnt_q <= '0;
        end else if (cmd_xfer) begin
            if (cp_eop) begin
                beat_cnt_q <= '0;
            end else begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Back-pressure and read data
    // --------------------------------------------------

    assign waitrequest = ~cp_ready;
    assign readdata    = rsp_data[PKT_DATA_H:PKT_DATA_L];

    // Beats with no enabled byte carry nothing for the master
    assign readdatavalid = rsp_valid & (rsp_data[PKT_BYTEEN_H:PKT_BYTEEN_L] != '0);

endmodule

`default_nettype wire

// ==== cmd_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module cmd_arbiter import bus_pkg::*, pkt_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,

    // Command streams from the agents
    input  wire logic req_valid [NUM_MASTERS],
    input  wire pkt_t req_data  [NUM_MASTERS],
    input  wire logic req_sop   [NUM_MASTERS],
    input  wire logic req_eop   [NUM_MASTERS],
    output logic      req_ready [NUM_MASTERS],

    // Merged stream to the slave
    output logic      s_valid,
    output pkt_t      s_data,
    output logic      s_sop,
    output logic      s_eop,
    input  wire logic s_ready
);

    typedef enum logic {
        ARB_IDLE,
        ARB_LOCKED
    } arb_state_t;

    arb_state_t state_q;
    // Master with first pick in the next round
    master_id_t ptr_q;
    // Owner of a packet that is in flight
    master_id_t grant_q;
    master_id_t pick;
    master_id_t sel;
    logic       found;
    logic       xfer;

    // --------------------------------------------------
    // Round-robin pick
    // --------------------------------------------------

    // Scan from the pointer, first requester wins
    always_comb begin
        pick  = ptr_q;
        found = 1'b0;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (!found && req_valid[(int'(ptr_q) + i) % NUM_MASTERS]) begin
                pick  = master_id_t'((int'(ptr_q) + i) % NUM_MASTERS);
                found = 1'b1;
            end
        end
    end

    // A locked packet keeps its owner until the last beat
    assign sel = (state_q == ARB_LOCKED) ? grant_q : pick;

    // --------------------------------------------------
    // Stream mux
    // --------------------------------------------------

    assign s_valid = req_valid[sel];
    assign s_data  = req_data[sel];
    assign s_sop   = req_sop[sel];
    assign s_eop   = req_eop[sel];

    // Ready goes back to the selected agent only
    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            req_ready[i] = s_ready & (sel == master_id_t'(i));
        end
    end

    assign xfer = s_valid & s_ready;

    // --------------------------------------------------
    // Grant lock and pointer
    // --------------------------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= ARB_IDLE;
            ptr_q   <= '0;
            grant_q <= '0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    // Single-beat packets never lock
                    if (xfer && s_sop && !s_eop) begin
                        state_q <= ARB_LOCKED;
                        grant_q <= sel;
                    end
                end
                ARB_LOCKED: begin
                    if (xfer && s_eop) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase

            // Packet done, other master goes first next time
            if (xfer && s_eop) begin
                ptr_q <= master_id_t'((int'(sel) + 1) % NUM_MASTERS);
            end
        end
    end

endmodule

`default_nettype wire

// ==== mem_slave_agent.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_slave_agent import bus_pkg::*, pkt_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,

    // Command stream from the arbiter
    input  wire logic s_valid,
    input  wire pkt_t s_data,
    input  wire logic s_sop,
    input  wire logic s_eop,
    output logic      s_ready,

    // Read responses, valid routed by destination id
    output logic      rsp_valid [NUM_MASTERS],
    output pkt_t      rsp_data
);

    typedef enum logic {
        SLV_IDLE,
        SLV_READ
    } slv_state_t;

    slv_state_t  state_q;
    data_t       mem [MEM_WORDS];

    // Decoded command beat
    addr_t       cmd_addr;
    byteen_t     cmd_be;
    word_idx_t   cmd_word;
    logic        cmd_xfer;
    logic        wr_xfer;
    logic        rd_xfer;

    // Write burst tracking
    word_idx_t   wr_base_q;
    burstcount_t wr_beat_q;
    word_idx_t   wr_idx;

    // Read burst in progress
    word_idx_t   rd_word_q;
    burstcount_t rd_left_q;
    byteen_t     rd_be_q;
    master_id_t  rd_dest_q;

    // --------------------------------------------------
    // Command decode
    // --------------------------------------------------

    // Stalled while read beats stream out
    assign s_ready  = (state_q == SLV_IDLE);
    assign cmd_xfer = s_valid & s_ready;
    assign wr_xfer  = cmd_xfer & s_data[PKT_WRITE];
    assign rd_xfer  = cmd_xfer & s_data[PKT_READ];

    assign cmd_addr = s_data[PKT_ADDR_H:PKT_ADDR_L];
    assign cmd_be   = s_data[PKT_BYTEEN_H:PKT_BYTEEN_L];
    assign cmd_word = word_idx_t'(cmd_addr / BYTES_PER_WORD);

    // First beat takes its address from the packet itself
    assign wr_idx = (s_sop ? cmd_word : wr_base_q) + word_idx_t'(wr_beat_q);

    // --------------------------------------------------
    // Word memory
    // --------------------------------------------------

    // Byte lane writes under the enables
    always_ff @(posedge clk) begin
        if (wr_xfer) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (cmd_be[b]) begin
                    mem[wr_idx][8*b +: 8] <= s_data[PKT_DATA_L + 8*b +: 8];
                end
            end
        end
    end

    // --------------------------------------------------
    // Control FSM
    // --------------------------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q   <= SLV_IDLE;
            wr_beat_q <= '0;
            rd_left_q <= '0;
        end else begin
            if (wr_xfer) begin
                if (s_eop) begin
                    wr_beat_q <= '0;
                end else begin
                    wr_beat_q <= wr_beat_q + 1'b1;
                end
            end

            case (state_q)
                SLV_IDLE: begin
                    if (rd_xfer) begin
                        state_q   <= SLV_READ;
                        rd_left_q <= s_data[PKT_BURSTCOUNT_H:PKT_BURSTCOUNT_L];
                    end
                end
                SLV_READ: begin
                    // One response beat per cycle
                    rd_left_q <= rd_left_q - 1'b1;
                    if (rd_left_q <= burstcount_t'(1)) begin
                        state_q <= SLV_IDLE;
                    end
                end
                default: state_q <= SLV_IDLE;
            endcase
        end
    end

    // Addresses and ids captured from the command
    always_ff @(posedge clk) begin
        if (wr_xfer && s_sop) begin
            wr_base_q <= cmd_word;
        end
        if (rd_xfer) begin
            rd_word_q <= cmd_word;
            rd_be_q   <= cmd_be;
            rd_dest_q <= s_data[PKT_SRC_ID_H:PKT_SRC_ID_L];
        end else if (state_q == SLV_READ) begin
            rd_word_q <= rd_word_q + 1'b1;
        end
    end

    // --------------------------------------------------
    // Response beats
    // --------------------------------------------------

    always_comb begin
        rsp_data = '0;
        // Back to whoever sent the read
        rsp_data[PKT_DEST_ID_H:PKT_DEST_ID_L]       = rd_dest_q;
        rsp_data[PKT_BYTEEN_H:PKT_BYTEEN_L]         = rd_be_q;
        rsp_data[PKT_DATA_H:PKT_DATA_L]             = mem[rd_word_q];
        rsp_data[PKT_READ]                          = 1'b1;
        rsp_data[PKT_BURSTCOUNT_H:PKT_BURSTCOUNT_L] = rd_left_q;
        rsp_data[PKT_ADDR_H:PKT_ADDR_L]             = addr_t'(int'(rd_word_q) * BYTES_PER_WORD);
    end

    // Steering by id, no separate router
    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            rsp_valid[i] = (state_q == SLV_READ) & (rd_dest_q == master_id_t'(i));
        end
    end

endmodule

`default_nettype wire

// ==== fabric_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fabric_top import bus_pkg::*, pkt_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,

    // Master 0 bus
    input  wire addr_t       m0_address,
    input  wire logic        m0_write,
    input  wire logic        m0_read,
    input  wire data_t       m0_writedata,
    input  wire byteen_t     m0_byteenable,
    input  wire burstcount_t m0_burstcount,
    output logic             m0_waitrequest,
    output data_t            m0_readdata,
    output logic             m0_readdatavalid,

    // Master 1 bus
    input  wire addr_t       m1_address,
    input  wire logic        m1_write,
    input  wire logic        m1_read,
    input  wire data_t       m1_writedata,
    input  wire byteen_t     m1_byteenable,
    input  wire burstcount_t m1_burstcount,
    output logic             m1_waitrequest,
    output data_t            m1_readdata,
    output logic             m1_readdatavalid
);

    // --------------------------------------------------
    // Fabric wiring
    // --------------------------------------------------

    // Agent command streams
    logic cp_valid [NUM_MASTERS];
    pkt_t cp_data  [NUM_MASTERS];
    logic cp_sop   [NUM_MASTERS];
    logic cp_eop   [NUM_MASTERS];
    logic cp_ready [NUM_MASTERS];

    // Arbitrated stream into the slave
    logic s_valid;
    pkt_t s_data;
    logic s_sop;
    logic s_eop;
    logic s_ready;

    // Responses, data shared by both agents
    logic rsp_valid [NUM_MASTERS];
    pkt_t rsp_data;

    master_agent #(.ID(master_id_t'(0))) u_agent0 (
        .clk           (clk),
        .reset         (reset),
        .address       (m0_address),
        .write         (m0_write),
        .read          (m0_read),
        .writedata     (m0_writedata),
        .byteenable    (m0_byteenable),
        .burstcount    (m0_burstcount),
        .waitrequest   (m0_waitrequest),
        .readdata      (m0_readdata),
        .readdatavalid (m0_readdatavalid),
        .cp_valid      (cp_valid[0]),
        .cp_data       (cp_data[0]),
        .cp_sop        (cp_sop[0]),
        .cp_eop        (cp_eop[0]),
        .cp_ready      (cp_ready[0]),
        .rsp_valid     (rsp_valid[0]),
        .rsp_data      (rsp_data)
    );

    master_agent #(.ID(master_id_t'(1))) u_agent1 (
        .clk           (clk),
        .reset         (reset),
        .address       (m1_address),
        .write         (m1_write),
        .read          (m1_read),
        .writedata     (m1_writedata),
        .byteenable    (m1_byteenable),
        .burstcount    (m1_burstcount),
        .waitrequest   (m1_waitrequest),
        .readdata      (m1_readdata),
        .readdatavalid (m1_readdatavalid),
        .cp_valid      (cp_valid[1]),
        .cp_data       (cp_data[1]),
        .cp_sop        (cp_sop[1]),
        .cp_eop        (cp_eop[1]),
        .cp_ready      (cp_ready[1]),
        .rsp_valid     (rsp_valid[1]),
        .rsp_data      (rsp_data)
    );

    cmd_arbiter u_arb (
        .clk       (clk),
        .reset     (reset),
        .req_valid (cp_valid),
        .req_data  (cp_data),
        .req_sop   (cp_sop),
        .req_eop   (cp_eop),
        .req_ready (cp_ready),
        .s_valid   (s_valid),
        .s_data    (s_data),
        .s_sop     (s_sop),
        .s_eop     (s_eop),
        .s_ready   (s_ready)
    );

    mem_slave_agent u_slave (
        .clk       (clk),
        .reset     (reset),
        .s_valid   (s_valid),
        .s_data    (s_data),
        .s_sop     (s_sop),
        .s_eop     (s_eop),
        .s_ready   (s_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

endmodule

`default_nettype wire

// ==== fabric_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module fabric_props import bus_pkg::*, pkt_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic req_valid [NUM_MASTERS],
    input  wire logic req_ready [NUM_MASTERS],
    input  wire logic s_valid,
    input  wire pkt_t s_data,
    input  wire logic s_ready,
    input  wire logic s_sop,
    input  wire logic s_eop
);

    int         violations = 0;
    // Multi-beat packet in flight and its owner
    logic       in_pkt_q;
    master_id_t owner_q;
    // Sender of the beat on the merged stream
    master_id_t src_id;
    logic       any_req;

    assign src_id  = s_data[PKT_SRC_ID_H:PKT_SRC_ID_L];
    assign any_req = req_valid[0] | req_valid[1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_pkt_q <= 1'b0;
            owner_q  <= '0;
        end else if (s_valid && s_ready && s_sop && !s_eop) begin
            in_pkt_q <= 1'b1;
            owner_q  <= src_id;
        end else if (s_valid && s_ready && s_eop) begin
            in_pkt_q <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Grant and framing
    // --------------------------------------------------

    // Outside a packet the single ready lands on an agent that asks
    a_one_ready: assert property (@(posedge clk) disable iff (reset)
        !(req_ready[0] && req_ready[1]) &&
        (in_pkt_q || !s_ready || !any_req ||
         (req_ready[0] && req_valid[0]) || (req_ready[1] && req_valid[1])))
        else begin
            violations++;
            $error("Command ready went to both agents or to an idle agent");
        end

    // Every beat of an open packet comes from the agent that started it
    a_grant_held: assert property (@(posedge clk) disable iff (reset)
        (in_pkt_q && s_valid) |-> (src_id == owner_q))
        else begin
            violations++;
            $error("Grant moved to another agent inside a packet");
        end

    // Byte offset is dropped before a command reaches the slave
    a_word_aligned: assert property (@(posedge clk) disable iff (reset)
        s_valid |-> (s_data[PKT_ADDR_L +: $clog2(BYTES_PER_WORD)] == '0))
        else begin
            violations++;
            $error("Command address was not aligned to a word");
        end

    a_quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !s_valid)
        else begin
            violations++;
            $error("Command valid was high right after reset");
        end

endmodule

bind cmd_arbiter fabric_props u_props (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .s_valid   (s_valid),
    .s_data    (s_data),
    .s_ready   (s_ready),
    .s_sop     (s_sop),
    .s_eop     (s_eop)
);

`default_nettype wire

// ==== fabric_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module fabric_checker import bus_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,

    // Request side, for the response timing check
    input  wire logic        read          [NUM_MASTERS],
    input  wire logic        waitrequest   [NUM_MASTERS],
    input  wire byteen_t     byteenable    [NUM_MASTERS],
    input  wire burstcount_t burstcount    [NUM_MASTERS],

    // Read data from the fabric
    input  wire data_t       readdata      [NUM_MASTERS],
    input  wire logic        readdatavalid [NUM_MASTERS]
);

    // Expected beats per master, oldest first
    data_t exp_q [NUM_MASTERS][$];
    data_t exp_word;

    int beats_expected = 0;
    int beats_seen     = 0;
    int mismatches     = 0;
    int other_fails    = 0;
    // Expected beats not yet received, all masters
    int pending        = 0;
    // Beats still due on the cycles following an accepted read
    int due_left [NUM_MASTERS];

    initial begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            due_left[m] = 0;
        end
    end

    task automatic add_expected(input int m, input data_t d);
        exp_q[m].push_back(d);
        beats_expected++;
        pending++;
    endtask

    // --------------------------------------------------
    // Per-cycle compare
    // --------------------------------------------------

    always @(posedge clk) begin
        if (!reset) begin
            for (int m = 0; m < NUM_MASTERS; m++) begin
                if (readdatavalid[m]) begin
                    beats_seen++;
                    if (exp_q[m].size() == 0) begin
                        other_fails++;
                        $display("Master %0d got read data with no read outstanding", m);
                    end else begin
                        exp_word = exp_q[m].pop_front();
                        pending--;
                        if (readdata[m] !== exp_word) begin
                            mismatches++;
                            $display("FAIL m%0d_readdata got 0x%08h expected 0x%08h",
                                     m, readdata[m], exp_word);
                        end
                    end
                end
                // Beats must follow the accept with no gap
                if (due_left[m] > 0) begin
                    if (!readdatavalid[m]) begin
                        other_fails++;
                        $display("Master %0d read data did not arrive in the cycle it was due", m);
                    end
                    due_left[m]--;
                end
                if (read[m] && !waitrequest[m] && byteenable[m] != '0) begin
                    due_left[m] = int'(burstcount[m]);
                end
            end
        end
    end

    // --------------------------------------------------
    // End of run
    // --------------------------------------------------

    task automatic finish_check();
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if (exp_q[m].size() != 0) begin
                other_fails++;
                $display("Master %0d still waits for %0d read beats", m, exp_q[m].size());
            end
        end
        if (beats_seen != beats_expected) begin
            other_fails++;
            $display("Received %0d read beats but %0d were expected", beats_seen, beats_expected);
        end
    endtask

    task automatic print_counts(input int assert_fails, input int timeouts);
        $display("Counts: %0d of %0d beats, %0d mismatches, %0d other, %0d assertion, %0d timeout",
                 beats_seen, beats_expected, mismatches, other_fails, assert_fails, timeouts);
    endtask

endmodule

`default_nettype wire

// ==== tb_fabric.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fabric import bus_pkg::*; ();

    // Stim file layout
    localparam int MAX_LINES       = 64;
    localparam int STIM_COLS       = 6;
    localparam int COL_MASTER      = 0;
    localparam int COL_OP          = 1;
    localparam int COL_ADDR        = 2;
    localparam int COL_BURST       = 3;
    localparam int COL_BYTEEN      = 4;
    localparam int COL_DATA        = 5;
    localparam logic [31:0] OP_WRITE = 32'h1;

    // Run length budget
    localparam int CYCLES_PER_LINE = 20;
    localparam int TIMEOUT_SLACK   = 200;

    logic        clk;
    logic        reset;

    // Master-side buses, index is the master id
    addr_t       address       [NUM_MASTERS];
    logic        write         [NUM_MASTERS];
    logic        read          [NUM_MASTERS];
    data_t       writedata     [NUM_MASTERS];
    byteen_t     byteenable    [NUM_MASTERS];
    burstcount_t burstcount    [NUM_MASTERS];
    logic        waitrequest   [NUM_MASTERS];
    data_t       readdata      [NUM_MASTERS];
    logic        readdatavalid [NUM_MASTERS];

    // Raw stim words and the lines each master owns
    logic [31:0] stim_words [STIM_COLS*MAX_LINES];
    int          lines_q    [NUM_MASTERS][$];
    int          num_lines   = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    fabric_top uut (
        .clk              (clk),
        .reset            (reset),
        .m0_address       (address[0]),
        .m0_write         (write[0]),
        .m0_read          (read[0]),
        .m0_writedata     (writedata[0]),
        .m0_byteenable    (byteenable[0]),
        .m0_burstcount    (burstcount[0]),
        .m0_waitrequest   (waitrequest[0]),
        .m0_readdata      (readdata[0]),
        .m0_readdatavalid (readdatavalid[0]),
        .m1_address       (address[1]),
        .m1_write         (write[1]),
        .m1_read          (read[1]),
        .m1_writedata     (writedata[1]),
        .m1_byteenable    (byteenable[1]),
        .m1_burstcount    (burstcount[1]),
        .m1_waitrequest   (waitrequest[1]),
        .m1_readdata      (readdata[1]),
        .m1_readdatavalid (readdatavalid[1])
    );

    fabric_checker u_checker (
        .clk           (clk),
        .reset         (reset),
        .read          (read),
        .waitrequest   (waitrequest),
        .byteenable    (byteenable),
        .burstcount    (burstcount),
        .readdata      (readdata),
        .readdatavalid (readdatavalid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // Stim access and bus driving
    // --------------------------------------------------

    function automatic logic [31:0] stim_field(input int line, input int col);
        return stim_words[line*STIM_COLS + col];
    endfunction

    task automatic load_stim();
        // Unused words keep a value no master id can take
        for (int w = 0; w < STIM_COLS*MAX_LINES; w++) begin
            stim_words[w] = 32'hf000_0000 | 32'(w);
        end
        $readmemh("fabric_stim.txt", stim_words);
        for (int l = 0; l < MAX_LINES; l++) begin
            if (stim_field(l, COL_MASTER) < 32'(NUM_MASTERS)) begin
                lines_q[int'(stim_field(l, COL_MASTER))].push_back(l);
                num_lines++;
            end
        end
    endtask

    task automatic set_idle(input int m);
        address[m]    = '0;
        write[m]      = 1'b0;
        read[m]       = 1'b0;
        writedata[m]  = '0;
        byteenable[m] = '0;
        burstcount[m] = '0;
    endtask

    // One bus request, held until the fabric takes it
    task automatic issue_request(input int m, input int idx, input logic is_write);
        @(negedge clk);
        address[m]    = addr_t'(stim_field(idx, COL_ADDR));
        write[m]      = is_write;
        read[m]       = !is_write;
        writedata[m]  = is_write ? data_t'(stim_field(idx, COL_DATA)) : '0;
        byteenable[m] = byteen_t'(stim_field(idx, COL_BYTEEN));
        burstcount[m] = burstcount_t'(stim_field(idx, COL_BURST));
        @(posedge clk);
        while (waitrequest[m]) @(posedge clk);
    endtask

    task automatic run_master(input int m);
        int i;
        int idx;
        int n;
        i = 0;
        while (i < lines_q[m].size()) begin
            idx = lines_q[m][i];
            if (stim_field(idx, COL_OP) == OP_WRITE) begin
                // Each write line is one beat of its burst
                issue_request(m, idx, 1'b1);
                i++;
            end else begin
                n = int'(stim_field(idx, COL_BURST));
                // Nothing comes back when no byte is enabled
                if (stim_field(idx, COL_BYTEEN) != 32'h0) begin
                    for (int k = 0; k < n; k++) begin
                        u_checker.add_expected(m, data_t'(stim_field(lines_q[m][i+k], COL_DATA)));
                    end
                end
                issue_request(m, idx, 1'b0);
                i += n;
            end
        end
        @(negedge clk);
        set_idle(m);
    endtask

    task automatic end_run(input logic timed_out);
        int fails;
        fails = u_checker.mismatches + u_checker.other_fails + uut.u_arb.u_props.violations;
        u_checker.print_counts(uut.u_arb.u_props.violations, timed_out ? 1 : 0);
        if (fails == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        reset = 1'b1;
        set_idle(0);
        set_idle(1);
        load_stim();
        cycle_limit = num_lines*CYCLES_PER_LINE + TIMEOUT_SLACK;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Masters run side by side on disjoint regions
        fork
            run_master(0);
            run_master(1);
        join
        while (u_checker.pending > 0) @(posedge clk);
        // Room for any stray beat to show up
        repeat (4) @(posedge clk);
        u_checker.finish_check();
        end_run(1'b0);
    end

    // Watchdog
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with requests or read data still outstanding",
                 cycle_count);
        end_run(1'b1);
    end

endmodule

`default_nettype wire

// ==== fabric_stim.txt ====
// master op address burstcount byteenable data, all hex, one line per beat
// op 1 is a write beat, op 0 a read where data is the expected read beat
0 1 10 1 f 11223344
0 1 10 1 3 aabbccdd
0 0 10 1 f 1122ccdd
0 1 20 4 f a0000001
0 1 20 4 f a0000002
0 1 20 4 f a0000003
0 1 20 4 f a0000004
0 0 20 4 f a0000001
0 0 20 4 f a0000002
0 0 20 4 f a0000003
0 0 20 4 f a0000004
0 0 13 1 f 1122ccdd
0 0 10 1 0 00000000
1 1 84 1 f 01020304
1 1 84 1 c deadbeef
1 0 84 1 f dead0304
1 1 a0 4 f b0000001
1 1 a0 4 f b0000002
1 1 a0 4 f b0000003
1 1 a0 4 f b0000004
1 0 a0 4 f b0000001
1 0 a0 4 f b0000002
1 0 a0 4 f b0000003
1 0 a0 4 f b0000004

// ==== sources.f ====
bus_pkg.sv
pkt_pkg.sv
master_agent.sv
cmd_arbiter.sv
mem_slave_agent.sv
fabric_top.sv
fabric_props.sv
fabric_checker.sv
tb_fabric.sv

// ==== Makefile ====
# Verilator build and run of the fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_fabric
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) fabric_stim.txt
	./$(SIM) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q '^Done: no errors$$' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
